/* source/uart_pkg.sv */
package uart_pkg;

    // register map, word addresses on the two-bit port address
    localparam logic [1:0] addr_din  = 2'd0; // data byte to send
    localparam logic [1:0] addr_con  = 2'd1; // control word
    localparam logic [1:0] addr_baud = 2'd2; // baud divisor
    localparam logic [1:0] addr_rco  = 2'd3; // status word, read only

    // cycles per bit = divisor + 1
    localparam int baud_w = 24;

    // control word fields
    localparam int con_en        = 0; // falling edge pushes din
    localparam int con_parity_lo = 1;
    localparam int con_parity_hi = 2;
    localparam int con_stop_sel  = 3; // 1 -> two stop bits

    // parity codes, 00 and 11 both mean no parity bit
    localparam logic [1:0] par_even = 2'b01;
    localparam logic [1:0] par_odd  = 2'b10;

    // status word fields
    localparam int rco_trmt     = 7; // buffer empty
    localparam int rco_txbf     = 6; // buffer full
    localparam int rco_count_lo = 1; // occupancy sits in bits 5:1
    localparam int rco_wrdone   = 0; // high in last stop bit

    // serial frame phases
    typedef enum logic [2:0] {
        s_idle,
        s_start,
        s_data,
        s_parity,
        s_stop
    } tx_state_t;

endpackage

/* source/uart_reg_decode.sv */
module uart_reg_decode
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              nrst,
    input  logic              wr,          // one-cycle write strobe
    input  logic [1:0]        addr,
    input  logic [31:0]       wdata,
    output logic [7:0]        din,         // last byte written to DIN
    output logic              con_en,
    output logic [1:0]        parity,
    output logic              stop_sel,
    output logic [baud_w-1:0] baudcontrol,
    output logic              push         // one cycle, on EN falling
);

    logic en_q; // EN one cycle late

    // write decode, one register per address
    // the port con_en hides the package bit position of the same name,
    // so that one is reached by its full path
    always_ff @(posedge clk) begin
        if (!nrst) begin
            din         <= '0;
            con_en      <= 1'b0;
            parity      <= 2'b00;     // no parity
            stop_sel    <= 1'b0;      // one stop bit
            baudcontrol <= '0;
        end else if (wr) begin
            case (addr)
                addr_din: begin
                    din <= wdata[7:0];
                end
                addr_con: begin
                    con_en   <= wdata[uart_pkg::con_en];
                    parity   <= wdata[con_parity_hi:con_parity_lo];
                    stop_sel <= wdata[con_stop_sel];
                end
                addr_baud: begin
                    baudcontrol <= wdata[baud_w-1:0];
                end
                default: begin
                    // status word is read only, writes ignored
                end
            endcase
        end
    end

    // keep last cycle's EN so the falling edge can be seen
    always_ff @(posedge clk) begin
        if (!nrst) begin
            en_q <= 1'b0;
        end else begin
            en_q <= con_en;
        end
    end

    // software raises EN and then clears it
    // the byte goes in once however long EN was held
    // high only in the first cycle after the clearing write
    assign push = en_q & ~con_en;

endmodule

/* source/tx_buffer.sv */
module tx_buffer #(
    parameter int buf_depth = 16
) (
    input  logic                               clk,
    input  logic                               nrst,
    input  logic                               push,  // dropped when full
    input  logic                               pop,   // ignored when empty
    input  logic [7:0]                         din,
    output logic [7:0]                         dout,  // head entry, always visible
    output logic [$clog2(buf_depth+1)-1:0]     count,
    output logic                               empty,
    output logic                               full
);

    localparam int aw = (buf_depth > 1) ? $clog2(buf_depth) : 1;
    localparam int cw = $clog2(buf_depth+1);

    logic [7:0]    mem [buf_depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic          do_push;
    logic          do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // storage, no reset needed since count guards the reads
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // pointers wrap at buf_depth, which need not be a power of two
    always_ff @(posedge clk) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == aw'(buf_depth-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == aw'(buf_depth-1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            // push and pop together leave count alone
        end
    end

    assign dout  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == cw'(buf_depth));

endmodule

/* source/uart_encoder.sv */
module uart_encoder
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              nrst,
    input  logic [7:0]        dout,        // head of the buffer
    input  logic              empty,
    input  logic [1:0]        parity,
    input  logic              stop_sel,
    input  logic [baud_w-1:0] baudcontrol,
    output logic              pop,         // one cycle per loaded byte
    output logic              tx,          // serial line, idles high
    output logic              wrdone       // high in the final stop bit
);

    tx_state_t         state;
    logic [baud_w-1:0] clk_count;  // cycles spent in the current bit
    logic [baud_w-1:0] baud_q;     // divisor for this frame
    logic [2:0]        bit_idx;    // data bit being sent
    logic [7:0]        shreg;      // data, lsb goes out first
    logic              par_bit;
    logic              par_on;     // frame carries a parity bit
    logic              two_stop;   // frame ends with two stop bits
    logic              stop_done;  // first stop bit already sent
    logic              bit_end;    // last cycle of the current bit
    logic              last_stop;  // stop bit now sending is the final one
    logic              load;

    assign bit_end   = (clk_count == baud_q);
    assign last_stop = ~two_stop | stop_done;

    // take the head byte from idle, or straight after the last stop bit
    assign load = ~empty & ((state == s_idle) |
                            ((state == s_stop) & bit_end & last_stop));
    assign pop  = load;

    // frame fsm, settings are captured at load so mid-frame writes wait
    always_ff @(posedge clk) begin
        if (!nrst) begin
            state     <= s_idle;
            clk_count <= '0;
            baud_q    <= '0;
            bit_idx   <= '0;
            par_on    <= 1'b0;
            two_stop  <= 1'b0;
            stop_done <= 1'b0;
        end else if (load) begin
            state     <= s_start;             // start bit from next cycle
            clk_count <= '0;
            baud_q    <= baudcontrol;
            bit_idx   <= '0;
            par_on    <= (parity == par_even) | (parity == par_odd);
            two_stop  <= stop_sel;
            stop_done <= 1'b0;
        end else if (state != s_idle) begin
            if (!bit_end) begin
                clk_count <= clk_count + 1'b1;
            end else begin
                clk_count <= '0;
                case (state)
                    s_start: state <= s_data;
                    s_data: begin
                        bit_idx <= bit_idx + 1'b1;    // wraps to 0 after bit 7
                        if (bit_idx == 3'd7) begin
                            state <= par_on ? s_parity : s_stop;
                        end
                    end
                    s_parity: state <= s_stop;
                    s_stop: begin
                        stop_done <= 1'b1;
                        if (last_stop) begin
                            state <= s_idle;      // buffer ran dry
                        end
                    end
                    default: state <= s_idle;
                endcase
            end
        end
    end

    // payload side, shift register and parity bit
    always_ff @(posedge clk) begin
        if (load) begin
            shreg   <= dout;
            // even parity makes the ones count even, odd inverts it
            par_bit <= (parity == par_odd) ? ~(^dout) : ^dout;
        end else if (state == s_data && bit_end) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

    // line level per phase
    always_comb begin
        tx     = 1'b1;
        wrdone = 1'b0;
        case (state)
            s_start:  tx = 1'b0;
            s_data:   tx = shreg[0];
            s_parity: tx = par_bit;
            s_stop: begin
                tx     = 1'b1;
                wrdone = last_stop;   // only the final stop bit
            end
            default:  tx = 1'b1;      // idle, line held high
        endcase
    end

endmodule

/* source/uart_readback.sv */
module uart_readback
    import uart_pkg::*;
#(
    parameter int buf_depth = 16
) (
    input  logic                           clk,
    input  logic                           nrst,
    input  logic                           rd,          // one-cycle read strobe
    input  logic [1:0]                     addr,
    input  logic [7:0]                     din,
    input  logic                           con_en,
    input  logic [1:0]                     parity,
    input  logic                           stop_sel,
    input  logic [baud_w-1:0]              baudcontrol,
    input  logic [$clog2(buf_depth+1)-1:0] count,
    input  logic                           empty,
    input  logic                           full,
    input  logic                           wrdone,
    output logic [31:0]                    rdata        // valid the cycle after rd
);

    localparam int cw = $clog2(buf_depth+1);

    logic [31:0] con_word;
    logic [31:0] rco_word;

    // control word rebuilt in its write layout
    // port con_en hides the package bit index, hence the full path
    always_comb begin
        con_word = '0;
        con_word[uart_pkg::con_en]            = con_en;
        con_word[con_parity_hi:con_parity_lo] = parity;
        con_word[con_stop_sel]                = stop_sel;
    end

    // status word
    always_comb begin
        rco_word = '0;
        rco_word[rco_trmt]             = empty;
        rco_word[rco_txbf]             = full;
        rco_word[rco_count_lo +: cw]   = count;   // 5 bits at depth 16
        rco_word[rco_wrdone]           = wrdone;
    end

    // registered mux, held between reads
    always_ff @(posedge clk) begin
        if (!nrst) begin
            rdata <= '0;
        end else if (rd) begin
            case (addr)
                addr_din:  rdata <= {24'd0, din};
                addr_con:  rdata <= con_word;
                addr_baud: rdata <= {{(32-baud_w){1'b0}}, baudcontrol};
                addr_rco:  rdata <= rco_word;
                default:   rdata <= '0;
            endcase
        end
    end

endmodule

/* source/uart_tx_periph.sv */
module uart_tx_periph
    import uart_pkg::*;
#(
    parameter int buf_depth = 16
) (
    input  logic        clk,
    input  logic        nrst,
    input  logic        wr,
    input  logic        rd,
    input  logic [1:0]  addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        tx
);

    localparam int cw = $clog2(buf_depth+1);

    logic [7:0]        din;
    logic              con_en;
    logic [1:0]        parity;
    logic              stop_sel;
    logic [baud_w-1:0] baudcontrol;
    logic              push;
    logic              pop;
    logic [7:0]        dout;
    logic [cw-1:0]     count;
    logic              empty;
    logic              full;
    logic              wrdone;

    // decode, register writes and the push pulse
    uart_reg_decode u_decode (
        .clk(clk), .nrst(nrst), .wr(wr), .addr(addr), .wdata(wdata),
        .din(din), .con_en(con_en), .parity(parity), .stop_sel(stop_sel),
        .baudcontrol(baudcontrol), .push(push)
    );

    // execute, byte buffer feeding the frame encoder
    tx_buffer #(.buf_depth(buf_depth)) u_buffer (
        .clk(clk), .nrst(nrst), .push(push), .pop(pop), .din(din),
        .dout(dout), .count(count), .empty(empty), .full(full)
    );

    uart_encoder u_encoder (
        .clk(clk), .nrst(nrst), .dout(dout), .empty(empty), .parity(parity),
        .stop_sel(stop_sel), .baudcontrol(baudcontrol),
        .pop(pop), .tx(tx), .wrdone(wrdone)
    );

    // result, read-back mux
    uart_readback #(.buf_depth(buf_depth)) u_readback (
        .clk(clk), .nrst(nrst), .rd(rd), .addr(addr), .din(din),
        .con_en(con_en), .parity(parity), .stop_sel(stop_sel),
        .baudcontrol(baudcontrol), .count(count), .empty(empty), .full(full),
        .wrdone(wrdone), .rdata(rdata)
    );

endmodule

/* verif/tx_line_monitor.sv */
module tx_line_monitor
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              nrst,
    input  logic              tx,
    input  logic              exp_valid,  // DUT takes the clearing CON write on this edge
    input  logic [7:0]        exp_data,
    input  logic [1:0]        exp_par,
    input  logic              exp_two,
    input  logic [baud_w-1:0] exp_baud,
    output int                errors,
    output logic              busy,       // a frame is being checked
    output int                pending     // bytes not yet started on tx
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] q_data [$];
    logic [1:0] q_par [$];
    logic       q_two [$];
    int         q_bit [$];   // cycles per bit
    logic       q_chain [$]; // byte queued behind one still waiting must follow with no idle gap
    int         gap;         // idle cycles since the last stop bit

    always @(posedge clk) begin
        if (exp_valid) begin
            q_chain.push_back(q_data.size() != 0);
            q_data.push_back(exp_data);
            q_par.push_back(exp_par);
            q_two.push_back(exp_two);
            q_bit.push_back(int'(exp_baud) + 1);
            pending = q_data.size();
        end
    end

    task automatic line_error(input string msg);
        errors++;
        $display("ERROR [%0t] %s", $time, msg);
    endtask

    // called on the first cycle of a start bit
    task automatic check_frame();
        logic [7:0] d;
        logic [1:0] p;
        logic       two;
        logic       chained;
        logic       want_par;
        int         n;
        int         half;
        if (q_data.size() == 0) begin
            line_error("a frame appeared on tx with no byte expected");
            while (tx !== 1'b1) @(negedge clk);
            return;
        end
        d       = q_data.pop_front();
        p       = q_par.pop_front();
        two     = q_two.pop_front();
        chained = q_chain.pop_front();
        n       = q_bit.pop_front();
        pending = q_data.size();
        busy    = 1'b1;
        half    = n / 2;              // mid-bit offset
        assert (!chained || gap == 0) else
            line_error($sformatf("frame 0x%02h began %0d cycles late", d, gap));
        repeat (half) @(negedge clk);
        assert (tx === 1'b0) else line_error("start bit high at mid-bit");
        for (int i = 0; i < 8; i++) begin
            repeat (n) @(negedge clk);
            assert (tx === d[i]) else
                line_error($sformatf("data bit %0d of 0x%02h read %b", i, d, tx));
        end
        if (p == par_even || p == par_odd) begin
            // the parity bit makes the ones count of the frame even or odd
            want_par = (p == par_even) ? ($countones(d) % 2 == 1) : ($countones(d) % 2 == 0);
            repeat (n) @(negedge clk);
            assert (tx === want_par) else
                line_error($sformatf("parity of 0x%02h read %b", d, tx));
        end
        repeat (n - half - 1) @(negedge clk); // last cycle of the bit before stop
        // every cycle of the stop time must be high
        for (int c = 0; c < (two ? 2 * n : n); c++) begin
            @(negedge clk);
            assert (tx === 1'b1) else
                line_error($sformatf("stop time of 0x%02h low at cycle %0d", d, c));
        end
        busy = 1'b0;
    endtask

    initial begin
        errors  = 0;
        busy    = 1'b0;
        pending = 0;
        gap     = 0;
        forever begin
            @(negedge clk);               // tx settled after the rising edge
            if (nrst === 1'b1 && tx === 1'b0) begin
                check_frame();
                gap = 0;
            end else begin
                gap++;
            end
        end
    end

endmodule

/* verif/uart_tb.sv */
module uart_tb
    import uart_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int buf_depth = 16;
    localparam int cw        = $clog2(buf_depth + 1);
    localparam int n_phases  = 8;
    localparam int max_bytes = 6;
    localparam int frame_max = 12 * 8;  // start, data, parity, two stop at 8 cycles per bit
    // one full frame per byte doubled for bus traffic plus slack for reset and polling
    localparam int cycle_limit = (n_phases * max_bytes + buf_depth + 2) * frame_max * 2 + 1000;

    logic              clk;
    logic              nrst;
    logic              wr;
    logic              rd;
    logic [1:0]        addr;
    logic [31:0]       wdata;
    logic [31:0]       rdata;
    logic              tx;
    logic              exp_valid;
    logic [7:0]        exp_data;
    logic [1:0]        exp_par;
    logic              exp_two;
    logic [baud_w-1:0] exp_baud;
    int                line_errors;
    logic              line_busy;
    int                line_pending;
    int                reg_errors = 0;
    int                cycles = 0;
    logic [1:0]        cur_par;        // frame settings now in the DUT
    logic              cur_two;
    logic [baud_w-1:0] cur_baud;
    logic [7:0]        last_din;       // last byte written to DIN

    uart_tx_periph #(.buf_depth(buf_depth)) uut (
        .clk(clk), .nrst(nrst), .wr(wr), .rd(rd), .addr(addr),
        .wdata(wdata), .rdata(rdata), .tx(tx)
    );

    tx_line_monitor mon (
        .clk(clk), .nrst(nrst), .tx(tx), .exp_valid(exp_valid), .exp_data(exp_data),
        .exp_par(exp_par), .exp_two(exp_two), .exp_baud(exp_baud),
        .errors(line_errors), .busy(line_busy), .pending(line_pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic count_error(input string msg);
        reg_errors++;
        $display("ERROR [%0t] %s", $time, msg);
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] want);
        assert (got === want) else
            count_error($sformatf("%s read 0x%08h, expected 0x%08h", what, got, want));
    endtask

    // CON layout with EN in bit 0, parity in bits 2:1 and stop select in bit 3
    function automatic logic [31:0] con_value(input logic [1:0] p, input logic two,
                                              input logic en);
        logic [31:0] w;
        w = '0;
        w[con_en] = en;
        w[con_parity_hi:con_parity_lo] = p;
        w[con_stop_sel] = two;
        return w;
    endfunction

    task automatic write_reg(input logic [1:0] a, input logic [31:0] d);
        @(posedge clk);
        wr    <= 1'b1;       // stays high until the next access or idle drops it
        rd    <= 1'b0;
        addr  <= a;
        wdata <= d;
    endtask

    task automatic read_reg(input logic [1:0] a, output logic [31:0] d);
        @(posedge clk);
        wr   <= 1'b0;
        rd   <= 1'b1;
        addr <= a;
        @(posedge clk);      // rdata registered here
        rd <= 1'b0;
        @(negedge clk);
        d = rdata;
    endtask

    task automatic push_byte(input logic [7:0] b, input logic keep);
        last_din = b;
        write_reg(addr_din, {24'd0, b});
        write_reg(addr_con, con_value(cur_par, cur_two, 1'b1));
        write_reg(addr_con, con_value(cur_par, cur_two, 1'b0)); // EN falls and the byte goes in
        exp_valid <= keep;                                      // dropped bytes stay out
        exp_data  <= b;
        exp_par   <= cur_par;
        exp_two   <= cur_two;
        exp_baud  <= cur_baud;
        @(posedge clk);
        wr        <= 1'b0;
        exp_valid <= 1'b0;
    endtask

    // write new settings and read DIN, CON and BAUD back
    task automatic set_format(input logic [1:0] p, input logic two, input logic [baud_w-1:0] b);
        logic [31:0] rv;
        cur_par  = p;
        cur_two  = two;
        cur_baud = b;
        write_reg(addr_con, con_value(p, two, 1'b0));
        write_reg(addr_baud, 32'(b));
        read_reg(addr_din, rv);
        check_word("DIN", rv, {24'd0, last_din});
        read_reg(addr_con, rv);
        check_word("CON", rv, con_value(p, two, 1'b0));
        read_reg(addr_baud, rv);
        check_word("BAUD", rv, 32'(b));
    endtask

    task automatic wait_empty();
        logic [31:0] rv;
        rv = '0;
        while (!rv[rco_trmt]) read_reg(addr_rco, rv);   // poll TRMT
    endtask

    task automatic wait_line_idle();
        @(posedge clk);
        while (line_pending != 0 || line_busy) @(posedge clk);
        repeat (2) @(posedge clk);  // encoder back in idle
    endtask

    initial begin
        logic [31:0] rv;
        logic [31:0] want;
        int          model_count;   // buffer occupancy in the model
        int          nb;
        rv        = $urandom(32'h2485);   // seeds the generator
        nrst      = 1'b0;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = 2'd0;
        wdata     = '0;
        exp_valid = 1'b0;
        exp_data  = '0;
        exp_par   = '0;
        exp_two   = 1'b0;
        exp_baud  = '0;
        cur_par   = '0;
        cur_two   = 1'b0;
        cur_baud  = '0;
        last_din  = '0;
        repeat (4) @(posedge clk);
        nrst <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            assert (tx === 1'b1) else count_error("tx not high after reset");
        end
        want = '0;
        want[rco_trmt] = 1'b1;
        read_reg(addr_rco, rv);
        check_word("RCO after reset", rv, want);

        // each phase picks a random format and sends a few bytes
        for (int ph = 0; ph < n_phases; ph++) begin
            set_format(2'($urandom_range(3, 0)), 1'($urandom_range(1, 0)),
                       baud_w'($urandom_range(7, 1)));
            nb = $urandom_range(max_bytes, 1);
            repeat (nb) push_byte(8'($urandom), 1'b1);
            wait_empty();
        end

        // burst at the largest divisor while the first byte is on the line
        wait_line_idle();
        set_format(par_even, 1'b1, baud_w'(7));
        push_byte(8'($urandom), 1'b1);
        repeat (3) @(posedge clk);
        model_count = 0;
        for (int i = 0; i < buf_depth + 1; i++) begin
            if (model_count < buf_depth) begin
                push_byte(8'($urandom), 1'b1);
                model_count++;
            end else begin
                push_byte(8'($urandom), 1'b0);   // buffer full
            end
        end
        want = '0;
        want[rco_trmt] = (model_count == 0);
        want[rco_txbf] = (model_count == buf_depth);
        want[rco_count_lo +: cw] = cw'(model_count);
        read_reg(addr_rco, rv);
        rv[rco_wrdone] = 1'b0;   // depends on where the first frame is
        check_word("RCO after burst", rv, want);

        wait_empty();
        // the last frame raises WRDONE in its final stop bit
        rv = '0;
        while (!rv[rco_wrdone]) read_reg(addr_rco, rv);
        wait_line_idle();
        want = '0;
        want[rco_trmt] = 1'b1;
        read_reg(addr_rco, rv);
        check_word("RCO at end", rv, want);

        $display("errors: register checks %0d, serial line checks %0d", reg_errors, line_errors);
        if (reg_errors == 0 && line_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* files.f */
source/uart_pkg.sv
source/uart_reg_decode.sv
source/tx_buffer.sv
source/uart_encoder.sv
source/uart_readback.sv
source/uart_tx_periph.sv
verif/tx_line_monitor.sv
verif/uart_tb.sv
